//--- include/ramio_macros.svh
// ramio board constants
// address map of the hub and serial line timing

`ifndef RAMIO_MACROS_SVH
`define RAMIO_MACROS_SVH

// 4 KiB on-chip RAM, byte addressed from zero
`define RAM_ADDR_BITS 12

// memory mapped devices at the top of the address space
`define UART_ADDR 32'hFFFF_FFF8
`define LED_ADDR 32'hFFFF_FFFC

// serial timing, 8 clocks per bit
`define CLK_HZ 30_000_000
`define BAUD_RATE 3_750_000
`define CLOCKS_PER_BIT (`CLK_HZ / `BAUD_RATE)

`endif

//--- logic/ramio_pkg.sv
// ramio shared types
// access sizes of the core port, the hub and the RAM
// load sizes follow the RV32I load funct3 field

package ramio_pkg;

  // ----------------------------------------------------------
  // load sizes
  // ----------------------------------------------------------

  // bit 2 set means zero extension
  typedef enum logic [2:0] {
    read_byte   = 3'd0,  // lb, sign extended
    read_half   = 3'd1,  // lh, sign extended
    read_word   = 3'd2,  // lw
    read_byte_u = 3'd4,  // lbu
    read_half_u = 3'd5   // lhu
  } read_type_t;

  // ----------------------------------------------------------
  // store sizes
  // ----------------------------------------------------------

  // anything but none turns the access into a store
  typedef enum logic [1:0] {
    write_none = 2'd0,  // load
    write_byte = 2'd1,  // sb
    write_half = 2'd2,  // sh
    write_word = 2'd3   // sw
  } write_type_t;

endpackage

//--- logic/uart_tx.sv
// serial transmitter, 8N1
// start bit, eight data bits LSB first, one stop bit, idle high

`include "ramio_macros.svh"

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,   // one-cycle pulse, ignored while active
  input  logic [7:0] data,
  output logic       tx,      // serial line
  output logic       active   // frame in progress
);

  localparam int clks_per_bit = `CLOCKS_PER_BIT;
  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  logic [cnt_w-1:0] clk_cnt;  // clocks into the current bit
  logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [8:0]       shift_q;  // data bits then stop bit
  logic             bit_end;

  assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

  // ----------------------------------------------------------
  // bit timing and line
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      tx      <= 1'b1;  // idle high
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= 4'd0;
    end else if (!active) begin
      if (start) begin
        tx      <= 1'b0;  // start bit
        active  <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= 4'd0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        tx     <= 1'b1;  // stop bit over
        active <= 1'b0;
      end else begin
        tx      <= shift_q[0];  // next bit out
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // shift register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (start && !active) begin
      shift_q <= {1'b1, data};  // stop bit behind the data
    end else if (active && bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

//--- logic/ram_store.sv
// on-chip RAM of the hub
// 32-bit words with byte enables, sized stores and sized loads
// two-stage read, word fetch then align and extend

`include "ramio_macros.svh"

module ram_store (
  input  logic                         clk,
  input  logic                         read,        // one-cycle pulse
  input  logic                         write,       // one-cycle pulse
  input  logic [`RAM_ADDR_BITS-1:0]    address,     // byte address
  input  ramio_pkg::read_type_t        read_type,
  input  ramio_pkg::write_type_t       write_type,
  input  logic [31:0]                  data,
  output logic [31:0]                  rdata,
  output logic                         rvalid       // 2 cycles after read
);

  import ramio_pkg::*;

  localparam int words = 2 ** (`RAM_ADDR_BITS - 2);

  logic [31:0]               mem [words];
  logic [`RAM_ADDR_BITS-3:0] word_addr;
  logic [1:0]                offset;      // byte within word
  logic [3:0]                byte_en;
  logic [31:0]               lane_data;   // store data on its lanes
  logic                      s1_valid;
  logic [31:0]               s1_word;
  logic [1:0]                s1_offset;
  read_type_t                s1_type;
  logic [31:0]               s1_shifted;  // addressed byte or half at bit 0
  logic [31:0]               s2_next;

  assign word_addr = address[`RAM_ADDR_BITS-1:2];
  assign offset    = address[1:0];

  // ----------------------------------------------------------
  // store path
  // ----------------------------------------------------------

  assign lane_data = data << {offset, 3'b000};

  // aligned accesses only, misaligned is undefined
  always_comb begin
    case (write_type)
      write_byte: byte_en = 4'b0001 << offset;
      write_half: byte_en = 4'b0011 << {offset[1], 1'b0};
      write_word: byte_en = 4'b1111;
      default:    byte_en = 4'b0000;  // load
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write && byte_en[i]) begin
        mem[word_addr][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
  end

  // ----------------------------------------------------------
  // stage one, word fetch
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    s1_valid <= read;
    if (read) begin
      s1_word   <= mem[word_addr];
      s1_offset <= offset;     // kept for alignment
      s1_type   <= read_type;  // kept for extension
    end
  end

  // ----------------------------------------------------------
  // stage two, align and extend
  // ----------------------------------------------------------

  assign s1_shifted = s1_word >> {s1_offset, 3'b000};

  always_comb begin
    case (s1_type)
      read_byte:   s2_next = {{24{s1_shifted[7]}}, s1_shifted[7:0]};
      read_half:   s2_next = {{16{s1_shifted[15]}}, s1_shifted[15:0]};
      read_byte_u: s2_next = {24'b0, s1_shifted[7:0]};
      read_half_u: s2_next = {16'b0, s1_shifted[15:0]};
      default:     s2_next = s1_word;  // whole word
    endcase
  end

  always_ff @(posedge clk) begin
    rvalid <= s1_valid;
    rdata  <= s2_next;
  end

endmodule

//--- logic/ramio.sv
// ramio memory and I/O hub
// decodes each core access into RAM, serial transmit, LED register or unmapped
// every load answers exactly 2 cycles after its enable

`include "ramio_macros.svh"

module ramio (
  input  logic                         clk,
  input  logic                         reset,
  // core side
  input  logic                         enable,      // one-cycle pulse
  input  ramio_pkg::read_type_t        read_type,
  input  ramio_pkg::write_type_t       write_type,
  input  logic [31:0]                  address,
  input  logic [31:0]                  data_in,
  output logic [31:0]                  data_out,
  output logic                         data_out_ready,
  output logic                         busy,
  // board
  output logic [3:0]                   led,
  // RAM side
  output logic                         ram_read,
  output logic                         ram_write,
  output logic [`RAM_ADDR_BITS-1:0]    ram_address,
  output ramio_pkg::read_type_t        ram_read_type,
  output ramio_pkg::write_type_t       ram_write_type,
  output logic [31:0]                  ram_data,
  input  logic [31:0]                  ram_rdata,
  input  logic                         ram_rvalid,
  // serial transmitter
  output logic                         tx_start,
  output logic [7:0]                   tx_data,
  input  logic                         tx_active
);

  import ramio_pkg::*;

  logic        accept;       // enable that is not dropped
  logic        is_ram;
  logic        is_uart;
  logic        is_led;
  logic        is_store;
  logic [3:0]  led_q;
  logic        nr_valid_q1;  // non-RAM load, stage one
  logic        nr_valid_q2;
  logic [31:0] nr_data_q1;
  logic [31:0] nr_data_q2;

  // ----------------------------------------------------------
  // address decode
  // ----------------------------------------------------------

  assign is_ram   = (address[31:`RAM_ADDR_BITS] == '0);  // below 4 KiB
  assign is_uart  = (address == `UART_ADDR);
  assign is_led   = (address == `LED_ADDR);
  assign is_store = (write_type != write_none);

  // enables during busy are dropped
  assign accept = enable && !busy;

  // ----------------------------------------------------------
  // RAM port
  // ----------------------------------------------------------

  // pulses in the enable cycle, store lands on that edge
  assign ram_read       = accept && is_ram && !is_store;
  assign ram_write      = accept && is_ram && is_store;
  assign ram_address    = address[`RAM_ADDR_BITS-1:0];
  assign ram_read_type  = read_type;
  assign ram_write_type = write_type;
  assign ram_data       = data_in;

  // ----------------------------------------------------------
  // serial transmit and busy
  // ----------------------------------------------------------

  assign tx_start = accept && is_uart && is_store;
  assign tx_data  = data_in[7:0];  // low byte only

  // busy ends in the very cycle the stop bit ends
  assign busy = tx_active;

  // ----------------------------------------------------------
  // LED register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      led_q <= 4'b0000;
    end else if (accept && is_led && is_store) begin
      led_q <= data_in[3:0];
    end
  end

  assign led = led_q;

  // ----------------------------------------------------------
  // non-RAM loads, delayed to RAM latency
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      nr_valid_q1 <= 1'b0;
      nr_valid_q2 <= 1'b0;
    end else begin
      nr_valid_q1 <= accept && !is_ram && !is_store;
      nr_valid_q2 <= nr_valid_q1;
    end
  end

  // LED reads zero extended, UART and unmapped read zero
  always_ff @(posedge clk) begin
    nr_data_q1 <= is_led ? {28'b0, led_q} : 32'b0;
    nr_data_q2 <= nr_data_q1;
  end

  // same latency everywhere, so the two sources never collide
  assign data_out       = ram_rvalid ? ram_rdata : nr_data_q2;
  assign data_out_ready = ram_rvalid || nr_valid_q2;

endmodule

//--- logic/top.sv
// board top of the memory and I/O hub
// core-side port exposed, hub drives the RAM, the serial line and the LEDs

`include "ramio_macros.svh"

module top (
  input  logic                   clk,
  input  logic                   reset,
  // core side
  input  logic                   enable,
  input  ramio_pkg::read_type_t  read_type,
  input  ramio_pkg::write_type_t write_type,
  input  logic [31:0]            address,
  input  logic [31:0]            data_in,
  output logic [31:0]            data_out,
  output logic                   data_out_ready,
  output logic                   busy,
  // board
  output logic [5:0]             led,
  output logic                   uart_tx
);

  import ramio_pkg::*;

  // hub to RAM
  logic                      ram_read;
  logic                      ram_write;
  logic [`RAM_ADDR_BITS-1:0] ram_address;
  read_type_t                ram_read_type;
  write_type_t               ram_write_type;
  logic [31:0]               ram_data;
  logic [31:0]               ram_rdata;
  logic                      ram_rvalid;
  // hub to transmitter
  logic                      tx_start;
  logic [7:0]                tx_data;
  logic                      tx_active;

  // ----------------------------------------------------------
  // hub
  // ----------------------------------------------------------

  ramio ramio0 (
    .clk, .reset,
    .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy,
    .led(led[4:1]),
    .ram_read, .ram_write, .ram_address, .ram_read_type, .ram_write_type,
    .ram_data, .ram_rdata, .ram_rvalid,
    .tx_start, .tx_data, .tx_active
  );

  // ----------------------------------------------------------
  // RAM and serial line
  // ----------------------------------------------------------

  ram_store ram_store0 (
    .clk,
    .read(ram_read), .write(ram_write), .address(ram_address),
    .read_type(ram_read_type), .write_type(ram_write_type), .data(ram_data),
    .rdata(ram_rdata), .rvalid(ram_rvalid)
  );

  uart_tx uart_tx0 (
    .clk, .reset,
    .start(tx_start), .data(tx_data),
    .tx(uart_tx), .active(tx_active)
  );

  assign led[0] = 1'b0;   // no core, held off
  assign led[5] = ~busy;  // lit while the hub is free

endmodule

//--- tests/top_assertions.sv
// bound checks on the hub top
// a shadow RAM and LED register predict every load
// also covers load latency, reset state and the busy rules

`include "ramio_macros.svh"

module top_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   enable,
  input ramio_pkg::read_type_t  read_type,
  input ramio_pkg::write_type_t write_type,
  input logic [31:0]            address,
  input logic [31:0]            data_in,
  input logic [31:0]            data_out,
  input logic                   data_out_ready,
  input logic                   busy,
  input logic [5:0]             led,
  input logic                   uart_tx
);

  timeunit 1ns;
  timeprecision 100ps;

  import ramio_pkg::*;

  localparam int frame_clks = 10 * `CLOCKS_PER_BIT;  // start, 8 data, stop

  logic [7:0]                shadow [2 ** `RAM_ADDR_BITS];  // byte image of the RAM
  logic [3:0]                led_shadow;
  logic [`RAM_ADDR_BITS-1:0] ofs;
  logic                      in_ram;
  logic                      load_accept;
  logic                      store_accept;
  logic                      uart_store;
  logic [31:0]               exp_q1;   // expected load result, 1 cycle old
  logic [31:0]               exp_q2;
  int                        fail_count = 0;

  assign ofs          = address[`RAM_ADDR_BITS-1:0];
  assign in_ram       = (address[31:`RAM_ADDR_BITS] == '0);
  assign load_accept  = enable && !busy && (write_type == write_none);
  assign store_accept = enable && !busy && (write_type != write_none);
  assign uart_store   = store_accept && (address == `UART_ADDR);

  // load result by the RV32I rules, little endian
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input read_type_t rt);
    logic [`RAM_ADDR_BITS-1:0] a;
    logic [7:0]                b;
    logic [15:0]               h;
    a = addr[`RAM_ADDR_BITS-1:0];
    b = shadow[a];
    h = {shadow[a + 1'b1], b};
    if (addr[31:`RAM_ADDR_BITS] != '0) begin
      return (addr == `LED_ADDR) ? {28'b0, led_shadow} : 32'b0;  // devices and holes
    end
    case (rt)
      read_byte:   return {{24{b[7]}}, b};
      read_half:   return {{16{h[15]}}, h};
      read_byte_u: return {24'b0, b};
      read_half_u: return {16'b0, h};
      default:     return {shadow[a + 2'd3], shadow[a + 2'd2], h};
    endcase
  endfunction

  // ------------------------------------------------------------
  // shadow state
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (store_accept && in_ram) begin
      shadow[ofs] <= data_in[7:0];
      if (write_type != write_byte) begin
        shadow[ofs + 1'b1] <= data_in[15:8];
      end
      if (write_type == write_word) begin
        shadow[ofs + 2'd2] <= data_in[23:16];
        shadow[ofs + 2'd3] <= data_in[31:24];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      led_shadow <= 4'b0000;
    end else if (store_accept && address == `LED_ADDR) begin
      led_shadow <= data_in[3:0];
    end
  end

  always_ff @(posedge clk) begin
    exp_q1 <= expect_load(address, read_type);  // shadow before this edge's store
    exp_q2 <= exp_q1;
  end

  // ------------------------------------------------------------
  // properties
  // ------------------------------------------------------------

  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> !busy && !data_out_ready && uart_tx && led == 6'b100000)
    else begin
      fail_count++;
      $error("outputs not in their reset state after reset");
    end

  ready_latency: assert property (@(posedge clk) disable iff (reset)
    load_accept |-> ##2 data_out_ready)
    else begin
      fail_count++;
      $error("no data_out_ready 2 cycles after a load");
    end

  ready_only_for_load: assert property (@(posedge clk) disable iff (reset)
    data_out_ready |-> $past(load_accept, 2))
    else begin
      fail_count++;
      $error("data_out_ready without a load 2 cycles before");
    end

  read_value: assert property (@(posedge clk) disable iff (reset)
    load_accept |-> ##2 (data_out == exp_q2))
    else begin
      fail_count++;
      $error("load data differs from the shadow memory");
    end

  busy_frame: assert property (@(posedge clk) disable iff (reset)
    uart_store |=> busy [*frame_clks] ##1 !busy)
    else begin
      fail_count++;
      $error("busy not high for exactly one serial frame");
    end

  busy_source: assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> $past(uart_store))
    else begin
      fail_count++;
      $error("busy rose without a serial store");
    end

  busy_led: assert property (@(posedge clk) disable iff (reset)
    led[5] == !busy)
    else begin
      fail_count++;
      $error("led[5] is not the inverse of busy");
    end

  led_register: assert property (@(posedge clk) disable iff (reset)
    led[4:1] == led_shadow && !led[0])
    else begin
      fail_count++;
      $error("led[4:1] differs from the last LED store");
    end

endmodule

bind top top_assertions checks0 (
  .clk, .reset, .enable, .read_type, .write_type, .address, .data_in,
  .data_out, .data_out_ready, .busy, .led, .uart_tx
);

//--- tests/top_tb.sv
// testbench for the memory and I/O hub top
// plays the core, decodes the serial line and prints the totals
// load values, latency and busy rules are checked by the bound assertions

`include "ramio_macros.svh"

module top_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import ramio_pkg::*;

  localparam int clk_period = 8;
  localparam int bit_clks   = `CLOCKS_PER_BIT;
  localparam int frames     = 3;
  // reset, fill, word test, random, pipelined, serial, led, tail
  localparam int total_cycles = 4 + 70 + 10 + 2 * 200 + 24
                              + frames * (10 * bit_clks + 20) + 16 + 10;

  logic        clk = 1'b0;
  logic        reset;
  logic        enable;
  read_type_t  read_type;
  write_type_t write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [5:0]  led;
  logic        uart_tx;

  int          seed = 32'h24d5;
  int          serial_errors = 0;
  int          other_errors = 0;
  string       test_name = "reset";
  logic [7:0]  sent_bytes [$];  // frames not yet decoded

  top dut0 (
    .clk, .reset, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx
  );

  always #(clk_period / 2) clk = ~clk;

  // one access, enable left high so calls go back to back
  task automatic issue(input write_type_t wt, input read_type_t rt,
                       input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    enable     = 1'b1;
    write_type = wt;
    read_type  = rt;
    address    = addr;
    data_in    = data;
  endtask

  task automatic release_bus();
    @(posedge clk);
    #1;
    enable     = 1'b0;
    write_type = write_none;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy) begin
      if (n == limit) begin
        other_errors++;
        $display("error in %s: busy still high after %0d cycles", test_name, limit);
        return;
      end
      n++;
      @(negedge clk);
    end
  endtask

  // sized store or load in the filled low 256 bytes
  task automatic random_access();
    logic [31:0] r;
    logic [31:0] addr;
    r    = $random(seed);
    addr = {24'b0, r[7:0]};
    case (r[10:8])
      3'd0:    issue(write_byte, read_word, addr, $random(seed));
      3'd1:    issue(write_half, read_word, {addr[31:1], 1'b0}, $random(seed));
      3'd2:    issue(write_word, read_word, {addr[31:2], 2'b00}, $random(seed));
      3'd3:    issue(write_none, read_byte, addr, 32'b0);
      3'd4:    issue(write_none, read_byte_u, addr, 32'b0);
      3'd5:    issue(write_none, read_half, {addr[31:1], 1'b0}, 32'b0);
      3'd6:    issue(write_none, read_half_u, {addr[31:1], 1'b0}, 32'b0);
      default: issue(write_none, read_word, {addr[31:2], 2'b00}, 32'b0);
    endcase
    if (r[12]) begin
      release_bus();  // bubble now and then
    end
  endtask

  // ------------------------------------------------------------
  // serial decoder, samples mid-bit on the falling clock
  // ------------------------------------------------------------

  initial begin : serial_decoder
    logic [7:0] got;
    logic [7:0] want;
    forever begin
      @(negedge clk);
      if (!reset && uart_tx === 1'b0) begin
        repeat (bit_clks / 2 - 1) @(negedge clk);  // middle of the start bit
        for (int i = 0; i < 8; i++) begin
          repeat (bit_clks) @(negedge clk);
          got[i] = uart_tx;  // LSB first
        end
        repeat (bit_clks) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          serial_errors++;
          $display("error in %s: stop bit missing", test_name);
        end
        if (sent_bytes.size() == 0) begin
          serial_errors++;
          $display("error in %s: frame sent with no store behind it", test_name);
        end else begin
          want = sent_bytes.pop_front();
          if (got !== want) begin
            serial_errors++;
            $display("mismatch %s expected %02h actual %02h", test_name, want, got);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin : stimulus
    logic [31:0] r;
    reset      = 1'b1;
    enable     = 1'b0;
    read_type  = read_word;
    write_type = write_none;
    address    = 32'b0;
    data_in    = 32'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // fill first, so every later load hits known data
    test_name = "word store and load";
    for (int a = 0; a < 256; a += 4) begin
      issue(write_word, read_word, a, $random(seed));
    end
    issue(write_word, read_word, 32'h80, 32'hdead_beef);
    issue(write_none, read_word, 32'h80, 32'b0);
    issue(write_none, read_word, 32'h7c, 32'b0);
    release_bus();

    test_name = "sized accesses";
    repeat (200) random_access();
    release_bus();

    test_name = "pipelined loads";
    for (int a = 0; a < 64; a += 4) begin
      issue(write_none, (a % 8 == 0) ? read_word : read_byte, a, 32'b0);
    end
    release_bus();

    test_name = "serial transmit";
    for (int f = 0; f < frames; f++) begin
      r = $random(seed);
      sent_bytes.push_back(r[7:0]);
      issue(write_word, read_word, `UART_ADDR, r);
      release_bus();
      issue(write_word, read_word, 32'h10, ~r);  // dropped, hub is busy
      release_bus();
      wait_idle(20 * bit_clks);
      issue(write_none, read_word, 32'h10, 32'b0);  // old word still there
      release_bus();
    end

    test_name = "led register";
    issue(write_word, read_word, `LED_ADDR, 32'h1234_567a);
    issue(write_none, read_word, `LED_ADDR, 32'b0);
    issue(write_none, read_byte_u, `LED_ADDR, 32'b0);
    issue(write_none, read_word, 32'h0000_1000, 32'b0);  // just past the RAM
    issue(write_none, read_word, 32'h8000_0000, 32'b0);
    issue(write_none, read_word, `UART_ADDR, 32'b0);  // no receiver
    release_bus();
    repeat (4) @(posedge clk);

    if (sent_bytes.size() != 0) begin
      serial_errors++;
      $display("error: %0d serial frames never arrived", sent_bytes.size());
    end
    $display("serial errors %0d, other errors %0d, assertion errors %0d",
             serial_errors, other_errors, dut0.checks0.fail_count);
    if (serial_errors == 0 && other_errors == 0 && dut0.checks0.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(total_cycles * clk_period * 3 / 2);
    $display("timeout: run still going after %0d cycles", total_cycles * 3 / 2);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
logic/ramio_pkg.sv
logic/uart_tx.sv
logic/ram_store.sv
logic/ramio.sv
logic/top.sv
tests/top_assertions.sv
tests/top_tb.sv

//--- Bender.yml
package:
  name: ramio

export_include_dirs:
  - include

sources:
  # RTL, package first
  - include_dirs:
      - include
    files:
      - logic/ramio_pkg.sv
      - logic/uart_tx.sv
      - logic/ram_store.sv
      - logic/ramio.sv
      - logic/top.sv
  # testbench and its bound assertions
  - target: test
    include_dirs:
      - include
    files:
      - tests/top_assertions.sv
      - tests/top_tb.sv
